// ==== build.f ====
verilog/axi_pkg.sv
verilog/mem_pkg.sv
verilog/axi_rd_master.sv
verilog/axi_wr_master.sv
verilog/axi_master_top.sv
dv/axi_master_sva.sv
dv/axi_master_tb.sv

// ==== dv/axi_master_golden.txt ====
# op size addr aux data expect, all hex; aux is wstrb for dc_write, ic address for dual_read
# data is write data or the expected ic line of dual_read; expect is 0 for dc_write
ic_read   4 00000000 0        0 00035a5a00025a5a00015a5a00005a5a
ic_read   4 00000130 0        0 13035a5a13025a5a13015a5a13005a5a
dc_read   0 00000051 0        0 05035a5a05025a5a05015a5a05005a5a
dc_read   1 00000092 0        0 09035a5a09025a5a09015a5a09005a5a
dc_read   2 000000a4 0        0 0a035a5a0a025a5a0a015a5a0a005a5a
dc_read   4 000003f0 0        0 3f035a5a3f025a5a3f015a5a3f005a5a
dc_write  2 00000204 00f0     1111111122222222deadbeef33333333 0
dc_read   4 00000200 0        0 20035a5a20025a5adeadbeef20005a5a
dc_write  4 00000080 ffff     0123456789abcdeffedcba9876543210 0
ic_read   4 00000080 0        0 0123456789abcdeffedcba9876543210
dc_write  0 00000107 0080     00000000000000007700000000000000 0
dc_read   4 00000100 0        0 10035a5a10025a5a77015a5a10005a5a
dual_read 4 00000030 00000040 04035a5a04025a5a04015a5a04005a5a 03035a5a03025a5a03015a5a03005a5a
dual_read 2 00000210 000002c0 2c035a5a2c025a5a2c015a5a2c005a5a 21035a5a21025a5a21015a5a21005a5a
dc_write  1 0000033e c000     beef0000000000000000000000000000 0
dual_read 4 00000330 00000340 34035a5a34025a5a34015a5a34005a5a beef5a5a33025a5a33015a5a33005a5a

// ==== dv/axi_master_sva.sv ====
`timescale 1ns/100ps

module axi_master_sva (
    input logic              clk,
    input logic              rst_n_i,
    input logic              arvalid_o,
    input logic              arready_i,
    input mem_pkg::addr_t    araddr_o,
    input logic              rvalid_i,
    input logic              rready_o,
    input logic              awvalid_o,
    input logic              awready_i,
    input mem_pkg::addr_t    awaddr_o,
    input logic              wvalid_o,
    input logic              wready_i,
    input mem_pkg::line_t    wdata_o,
    input logic              bvalid_i,
    input logic              bready_o
);
    int unsigned fail_count = 0;   // Read by the testbench at the end
    logic        ar_open_q;        // AR accepted, R beat still due
    logic        aw_open_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ar_open_q <= 1'b0;
            aw_open_q <= 1'b0;
        end else begin
            if (arvalid_o && arready_i) begin
                ar_open_q <= 1'b1;
            end else if (rvalid_i && rready_o) begin
                ar_open_q <= 1'b0;
            end
            if (awvalid_o && awready_i) begin
                aw_open_q <= 1'b1;
            end else if (bvalid_i && bready_o) begin
                aw_open_q <= 1'b0;
            end
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
        else begin $error("AR dropped or changed before arready"); fail_count++; end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
        else begin $error("AW dropped or changed before awready"); fail_count++; end

    w_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o))
        else begin $error("W dropped or changed before wready"); fail_count++; end

    r_after_ar: assert property (@(posedge clk) disable iff (!rst_n_i)
        rready_o |-> ar_open_q)
        else begin $error("rready raised with no accepted AR"); fail_count++; end

    b_after_aw: assert property (@(posedge clk) disable iff (!rst_n_i)
        bready_o |-> aw_open_q)
        else begin $error("bready raised with no accepted AW"); fail_count++; end

endmodule

// ==== dv/axi_master_tb.sv ====
`timescale 1ns/100ps

module axi_master_tb;
    import axi_pkg::*;
    import mem_pkg::*;

    localparam axi_id_t IC_ID         = 4'd2;
    localparam axi_id_t DC_ID         = 4'd5;
    localparam int      CYCLES_PER_OP = 200;

    logic       clk;
    logic       rst_n_i;
    logic       ic_rd_req_i, ic_rd_rdy_o, ic_ret_valid_o;
    logic       dc_rd_req_i, dc_rd_rdy_o, dc_ret_valid_o;
    logic       dc_wr_req_i, dc_wr_rdy_o, dc_wr_done_o;
    addr_t      ic_rd_addr_i, dc_rd_addr_i, dc_wr_addr_i, araddr_o, awaddr_o;
    xfer_size_t dc_rd_size_i, dc_wr_size_i, arsize_o, awsize_o;
    line_t      ic_ret_data_o, dc_ret_data_o, dc_wr_data_i, rdata_i, wdata_o;
    strb_t      dc_wr_strb_i, wstrb_o;
    axi_id_t    arid_o, rid_i, awid_o, wid_o, bid_i;
    axi_len_t   arlen_o, awlen_o;
    axi_burst_t arburst_o, awburst_o;
    axi_lock_t  arlock_o, awlock_o;
    axi_cache_t arcache_o, awcache_o;
    axi_prot_t  arprot_o, awprot_o;
    axi_resp_t  rresp_i, bresp_i;
    logic       arvalid_o, arready_i, rlast_i, rvalid_i, rready_o;
    logic       awvalid_o, awready_i, wlast_o, wvalid_o, wready_i, bvalid_i, bready_o;

    // Slave model state
    line_t      mem [64];
    integer     seed;
    int         error_count;
    int         rd_wait;
    logic       rd_pend;
    axi_id_t    rd_id_s, aw_id_s, w_id_s;
    xfer_size_t aw_size_s;
    logic       w_last_s;
    logic [5:0] rd_idx_s, aw_idx_s;
    logic       aw_got, w_got;
    line_t      w_data_s;
    strb_t      w_strb_s;
    axi_id_t    ar_id_log [$];
    xfer_size_t ar_size_log [$];

    // Operations from the golden file
    string       op_list [$];
    xfer_size_t  size_list [$];
    addr_t       addr_list [$];
    logic [31:0] aux_list [$];
    line_t       data_list [$];
    line_t       exp_list [$];
    int          watchdog_cycles;
    logic        ops_loaded = 1'b0;

    axi_master_top #(
        .IC_ID (IC_ID),
        .DC_ID (DC_ID)
    ) axi_master_top_i (.*);

    bind axi_master_top axi_master_sva sva_i (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic line_t fill_line(input int idx);
        logic [7:0] tag;
        tag = idx[7:0];
        return {tag, 8'h03, 16'h5a5a, tag, 8'h02, 16'h5a5a,
                tag, 8'h01, 16'h5a5a, tag, 8'h00, 16'h5a5a};
    endfunction

    task automatic check_line(input line_t got, input line_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_id(input axi_id_t got, input axi_id_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_size(input xfer_size_t got, input xfer_size_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // One INCR beat, normal access, no cache or protection hints
    task automatic check_attrs(input axi_len_t len, input axi_burst_t burst,
                               input axi_lock_t lock, input axi_cache_t cache,
                               input axi_prot_t prot, input string what);
        if (len !== 8'd0 || burst !== 2'd1 || lock !== 2'd0 || cache !== 4'd0
                || prot !== 3'd0) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s attrs %0d %0d %0d %0d %0d, expected 0 1 0 0 0",
                     $time, what, len, burst, lock, cache, prot);
        end
    endtask

    // AXI slave memory with random ready stalls
    always @(posedge clk) begin
        line_t merged;
        arready_i <= ($random(seed) & 3) != 0;
        awready_i <= ($random(seed) & 3) != 0;
        wready_i  <= ($random(seed) & 3) != 0;
        if (arvalid_o && arready_i) begin
            check_attrs(arlen_o, arburst_o, arlock_o, arcache_o, arprot_o, "AR");
            ar_id_log.push_back(arid_o);
            ar_size_log.push_back(arsize_o);
            rd_pend  <= 1'b1;
            rd_id_s  <= arid_o;
            rd_idx_s <= araddr_o[9:4];
            rd_wait  <= $random(seed) & 7;   // Read latency
        end else if (rd_pend && !rvalid_i) begin
            if (rd_wait == 0) begin
                rvalid_i <= 1'b1;
                rid_i    <= rd_id_s;
                rdata_i  <= mem[rd_idx_s];
                rd_pend  <= 1'b0;
            end else begin
                rd_wait <= rd_wait - 1;
            end
        end
        if (rvalid_i && rready_o) begin
            rvalid_i <= 1'b0;
        end
        if (awvalid_o && awready_i) begin
            check_attrs(awlen_o, awburst_o, awlock_o, awcache_o, awprot_o, "AW");
            aw_got    <= 1'b1;
            aw_id_s   <= awid_o;
            aw_size_s <= awsize_o;
            aw_idx_s  <= awaddr_o[9:4];
        end
        if (wvalid_o && wready_i) begin
            w_got    <= 1'b1;
            w_id_s   <= wid_o;
            w_last_s <= wlast_o;
            w_data_s <= wdata_o;
            w_strb_s <= wstrb_o;
        end
        if (aw_got && w_got && !bvalid_i) begin
            merged = mem[aw_idx_s];
            for (int b = 0; b < 16; b++) begin
                if (w_strb_s[b]) begin
                    merged[8*b +: 8] = w_data_s[8*b +: 8];
                end
            end
            mem[aw_idx_s] <= merged;
            bvalid_i      <= 1'b1;
            bid_i         <= aw_id_s;
            aw_got        <= 1'b0;
            w_got         <= 1'b0;
        end
        if (bvalid_i && bready_o) begin
            bvalid_i <= 1'b0;
        end
    end

    task automatic pop_ar_record(input axi_id_t exp_id, input xfer_size_t exp_size);
        if (ar_id_log.size() == 0) begin
            error_count++;
            $display("No AR handshake was seen for ID %0d at %0t", exp_id, $time);
        end else begin
            check_id(ar_id_log.pop_front(), exp_id, "arid");
            check_size(ar_size_log.pop_front(), exp_size, "arsize");
        end
    endtask

    task automatic issue_reads(
        input logic       use_dc,
        input logic       use_ic,
        input xfer_size_t dc_size,
        input addr_t      dc_addr,
        input addr_t      ic_addr,
        input line_t      dc_exp,
        input line_t      ic_exp
    );
        logic dc_open;
        logic ic_open;
        logic drop_dc;
        logic drop_ic;
        dc_open = use_dc;
        ic_open = use_ic;
        @(posedge clk);
        dc_rd_req_i  <= use_dc;
        dc_rd_size_i <= dc_size;
        dc_rd_addr_i <= dc_addr;
        ic_rd_req_i  <= use_ic;    // Same edge as dc for a dual read
        ic_rd_addr_i <= ic_addr;
        while (dc_open || ic_open) begin
            @(negedge clk);
            drop_dc = dc_rd_rdy_o;
            drop_ic = ic_rd_rdy_o;
            if (dc_ret_valid_o && dc_open) begin
                check_line(dc_ret_data_o, dc_exp, "dc_ret_data_o");
                dc_open = 1'b0;
            end else begin
                check_flag(dc_ret_valid_o, 1'b0, "dc_ret_valid_o with no dc read open");
            end
            if (ic_ret_valid_o && ic_open) begin
                check_line(ic_ret_data_o, ic_exp, "ic_ret_data_o");
                ic_open = 1'b0;
            end else begin
                check_flag(ic_ret_valid_o, 1'b0, "ic_ret_valid_o with no ic read open");
            end
            @(posedge clk);
            if (drop_dc) dc_rd_req_i <= 1'b0;   // AR taken on this edge
            if (drop_ic) ic_rd_req_i <= 1'b0;
        end
    endtask

    task automatic write_line(input xfer_size_t size, input addr_t addr, input strb_t strb,
                              input line_t data);
        @(posedge clk);
        dc_wr_req_i  <= 1'b1;
        dc_wr_size_i <= size;
        dc_wr_addr_i <= addr;
        dc_wr_strb_i <= strb;
        dc_wr_data_i <= data;
        do begin
            @(negedge clk);
        end while (!dc_wr_rdy_o);
        @(posedge clk);
        dc_wr_req_i <= 1'b0;
        @(negedge clk);
        while (!dc_wr_done_o) begin
            check_flag(dc_wr_rdy_o, 1'b0, "dc_wr_rdy_o while a write is open");
            @(negedge clk);
        end
        check_flag(dc_wr_rdy_o, 1'b1, "dc_wr_rdy_o in the done cycle");
        check_id(aw_id_s, DC_ID, "awid");
        check_size(aw_size_s, size, "awsize");
        check_id(w_id_s, DC_ID, "wid");
        check_flag(w_last_s, 1'b1, "wlast");
    endtask

    initial begin
        int          fd;
        int          code;
        int          sva_errors;
        string       text;
        string       op_s;
        xfer_size_t  size_s;
        addr_t       addr_s;
        logic [31:0] aux_s;
        line_t       data_s;
        line_t       exp_s;
        seed         = 32'hc66d;
        error_count  = 0;
        rd_pend      = 1'b0;
        rd_wait      = 0;
        aw_got       = 1'b0;
        w_got        = 1'b0;
        rst_n_i      = 1'b0;
        ic_rd_req_i  = 1'b0;
        ic_rd_addr_i = '0;
        dc_rd_req_i  = 1'b0;
        dc_rd_size_i = '0;
        dc_rd_addr_i = '0;
        dc_wr_req_i  = 1'b0;
        dc_wr_size_i = '0;
        dc_wr_addr_i = '0;
        dc_wr_strb_i = '0;
        dc_wr_data_i = '0;
        arready_i    = 1'b0;
        rid_i        = '0;
        rdata_i      = '0;
        rresp_i      = '0;
        rlast_i      = 1'b1;   // Every beat is the last
        rvalid_i     = 1'b0;
        awready_i    = 1'b0;
        wready_i     = 1'b0;
        bid_i        = '0;
        bresp_i      = '0;
        bvalid_i     = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = fill_line(i);
        end

        fd = $fopen("dv/axi_master_golden.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open dv/axi_master_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(text, fd);
                if (code > 0 && text.getc(0) != "#") begin
                    code = $sscanf(text, "%s %h %h %h %h %h",
                                   op_s, size_s, addr_s, aux_s, data_s, exp_s);
                    if (code == 6) begin
                        op_list.push_back(op_s);
                        size_list.push_back(size_s);
                        addr_list.push_back(addr_s);
                        aux_list.push_back(aux_s);
                        data_list.push_back(data_s);
                        exp_list.push_back(exp_s);
                    end
                end
            end
            $fclose(fd);
        end
        watchdog_cycles = (op_list.size() + 1) * CYCLES_PER_OP;
        ops_loaded      = 1'b1;

        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_flag(|{arvalid_o, rready_o, awvalid_o, wvalid_o, bready_o, ic_rd_rdy_o,
                     dc_rd_rdy_o, ic_ret_valid_o, dc_ret_valid_o, dc_wr_done_o},
                   1'b0, "idle outputs after reset");
        check_flag(dc_wr_rdy_o, 1'b1, "dc_wr_rdy_o after reset");

        foreach (op_list[i]) begin
            case (op_list[i])
                "ic_read": begin
                    issue_reads(1'b0, 1'b1, SIZE_LINE, '0, addr_list[i], '0, exp_list[i]);
                    pop_ar_record(IC_ID, SIZE_LINE);
                end
                "dc_read": begin
                    issue_reads(1'b1, 1'b0, size_list[i], addr_list[i], '0, exp_list[i], '0);
                    pop_ar_record(DC_ID, size_list[i]);
                end
                "dual_read": begin
                    issue_reads(1'b1, 1'b1, size_list[i], addr_list[i], aux_list[i],
                                exp_list[i], data_list[i]);
                    pop_ar_record(DC_ID, size_list[i]);   // Data cache wins the tie
                    pop_ar_record(IC_ID, SIZE_LINE);
                end
                "dc_write": begin
                    write_line(size_list[i], addr_list[i], aux_list[i][15:0], data_list[i]);
                end
                default: begin
                    error_count++;
                    $display("Unknown operation %s in the golden file", op_list[i]);
                end
            endcase
        end

        repeat (4) @(posedge clk);
        sva_errors = axi_master_top_i.sva_i.fail_count;
        $display("Errors: %0d check, %0d assertion", error_count, sva_errors);
        if (error_count == 0 && sva_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog, scaled to the number of golden lines
    initial begin
        wait (ops_loaded);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== verilog/axi_master_top.sv ====
`timescale 1ns/100ps

module axi_master_top #(
    parameter axi_pkg::axi_id_t IC_ID = 4'd0,
    parameter axi_pkg::axi_id_t DC_ID = 4'd1
) (
    input  logic                clk,
    input  logic                rst_n_i,

    // Instruction cache
    input  logic                ic_rd_req_i,
    input  mem_pkg::addr_t      ic_rd_addr_i,
    output logic                ic_rd_rdy_o,
    output logic                ic_ret_valid_o,
    output mem_pkg::line_t      ic_ret_data_o,

    // Data cache, read side
    input  logic                dc_rd_req_i,
    input  mem_pkg::xfer_size_t dc_rd_size_i,
    input  mem_pkg::addr_t      dc_rd_addr_i,
    output logic                dc_rd_rdy_o,
    output logic                dc_ret_valid_o,
    output mem_pkg::line_t      dc_ret_data_o,

    // Data cache, write side
    input  logic                dc_wr_req_i,
    input  mem_pkg::xfer_size_t dc_wr_size_i,
    input  mem_pkg::addr_t      dc_wr_addr_i,
    input  mem_pkg::strb_t      dc_wr_strb_i,
    input  mem_pkg::line_t      dc_wr_data_i,
    output logic                dc_wr_rdy_o,
    output logic                dc_wr_done_o,

    // AXI read address
    output axi_pkg::axi_id_t    arid_o,
    output mem_pkg::addr_t      araddr_o,
    output axi_pkg::axi_len_t   arlen_o,
    output mem_pkg::xfer_size_t arsize_o,
    output axi_pkg::axi_burst_t arburst_o,
    output axi_pkg::axi_lock_t  arlock_o,
    output axi_pkg::axi_cache_t arcache_o,
    output axi_pkg::axi_prot_t  arprot_o,
    output logic                arvalid_o,
    input  logic                arready_i,
    // AXI read data
    input  axi_pkg::axi_id_t    rid_i,
    input  mem_pkg::line_t      rdata_i,
    input  axi_pkg::axi_resp_t  rresp_i,
    input  logic                rlast_i,
    input  logic                rvalid_i,
    output logic                rready_o,
    // AXI write address
    output axi_pkg::axi_id_t    awid_o,
    output mem_pkg::addr_t      awaddr_o,
    output axi_pkg::axi_len_t   awlen_o,
    output mem_pkg::xfer_size_t awsize_o,
    output axi_pkg::axi_burst_t awburst_o,
    output axi_pkg::axi_lock_t  awlock_o,
    output axi_pkg::axi_cache_t awcache_o,
    output axi_pkg::axi_prot_t  awprot_o,
    output logic                awvalid_o,
    input  logic                awready_i,
    // AXI write data
    output axi_pkg::axi_id_t    wid_o,
    output mem_pkg::line_t      wdata_o,
    output mem_pkg::strb_t      wstrb_o,
    output logic                wlast_o,
    output logic                wvalid_o,
    input  logic                wready_i,
    // AXI write response
    input  axi_pkg::axi_id_t    bid_i,
    input  axi_pkg::axi_resp_t  bresp_i,
    input  logic                bvalid_i,
    output logic                bready_o
);
    import axi_pkg::*;

    // Port names match the channel masters one to one
    axi_rd_master #(
        .IC_ID (IC_ID),
        .DC_ID (DC_ID)
    ) u_axi_rd_master (.*);

    axi_wr_master #(
        .DC_ID (DC_ID)
    ) u_axi_wr_master (.*);

    // Single-beat INCR, normal access, no cache or protection hints
    assign arlen_o   = AXI_LEN_SINGLE;
    assign arburst_o = AXI_BURST_INCR;
    assign arlock_o  = '0;
    assign arcache_o = '0;
    assign arprot_o  = '0;

    assign awlen_o   = AXI_LEN_SINGLE;
    assign awburst_o = AXI_BURST_INCR;
    assign awlock_o  = '0;
    assign awcache_o = '0;
    assign awprot_o  = '0;

endmodule

// ==== verilog/axi_pkg.sv ====
package axi_pkg;

    // AXI3-style field widths as seen on the SoC bus
    typedef logic [3:0] axi_id_t;
    typedef logic [7:0] axi_len_t;     // Beats minus one
    typedef logic [1:0] axi_burst_t;
    typedef logic [1:0] axi_lock_t;
    typedef logic [3:0] axi_cache_t;
    typedef logic [2:0] axi_prot_t;
    typedef logic [1:0] axi_resp_t;

    // Every transfer is a single beat
    localparam axi_len_t AXI_LEN_SINGLE = 8'd0;

    localparam axi_burst_t AXI_BURST_INCR = 2'd1;  // Incrementing burst

endpackage

// ==== verilog/axi_rd_master.sv ====
`timescale 1ns/100ps

module axi_rd_master #(
    parameter axi_pkg::axi_id_t IC_ID = 4'd0,
    parameter axi_pkg::axi_id_t DC_ID = 4'd1
) (
    input  logic                clk,
    input  logic                rst_n_i,

    // Instruction cache, line reads only
    input  logic                ic_rd_req_i,
    input  mem_pkg::addr_t      ic_rd_addr_i,
    output logic                ic_rd_rdy_o,
    output logic                ic_ret_valid_o,
    output mem_pkg::line_t      ic_ret_data_o,

    // Data cache
    input  logic                dc_rd_req_i,
    input  mem_pkg::xfer_size_t dc_rd_size_i,
    input  mem_pkg::addr_t      dc_rd_addr_i,
    output logic                dc_rd_rdy_o,
    output logic                dc_ret_valid_o,
    output mem_pkg::line_t      dc_ret_data_o,

    // AR channel
    output axi_pkg::axi_id_t    arid_o,
    output mem_pkg::addr_t      araddr_o,
    output mem_pkg::xfer_size_t arsize_o,
    output logic                arvalid_o,
    input  logic                arready_i,

    // R channel
    input  axi_pkg::axi_id_t    rid_i,
    input  mem_pkg::line_t      rdata_i,
    input  axi_pkg::axi_resp_t  rresp_i,
    input  logic                rlast_i,
    input  logic                rvalid_i,
    output logic                rready_o
);
    import axi_pkg::*;
    import mem_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    rd_state_e  state_q;
    rd_state_e  state_d;
    logic       grant_dc_q;     // Owner of the outstanding read
    logic       take_req;
    logic       ar_hs;
    logic       r_hs;

    axi_id_t    arid_q;
    addr_t      araddr_q;
    xfer_size_t arsize_q;

    logic       ic_ret_valid_q;
    logic       dc_ret_valid_q;
    line_t      ret_data_q;     // Shared, qualified by the valids

    // Only sampled in idle, so the next AR waits for the ret cycle
    assign take_req = (state_q == RD_IDLE) && (dc_rd_req_i || ic_rd_req_i);

    assign arvalid_o = (state_q == RD_ADDR);
    assign ar_hs     = arvalid_o && arready_i;
    assign rready_o  = (state_q == RD_DATA);
    assign r_hs      = rvalid_i && rready_o;

    // Ack the client in the AR handshake cycle
    assign dc_rd_rdy_o = ar_hs && grant_dc_q;
    assign ic_rd_rdy_o = ar_hs && !grant_dc_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: begin
                if (take_req) begin
                    state_d = RD_ADDR;
                end
            end
            RD_ADDR: begin
                if (ar_hs) begin
                    state_d = RD_DATA;
                end
            end
            RD_DATA: begin
                if (r_hs) begin
                    state_d = RD_IDLE;
                end
            end
            default: state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= RD_IDLE;
            grant_dc_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (take_req) begin
                grant_dc_q <= dc_rd_req_i;  // Data cache wins a tie
            end
        end
    end

    // AR payload, held until arready
    always_ff @(posedge clk) begin
        if (take_req) begin
            if (dc_rd_req_i) begin
                arid_q   <= DC_ID;
                araddr_q <= dc_rd_addr_i;
                arsize_q <= dc_rd_size_i;
            end else begin
                arid_q   <= IC_ID;
                araddr_q <= ic_rd_addr_i;
                arsize_q <= SIZE_LINE;
            end
        end
    end

    assign arid_o   = arid_q;
    assign araddr_o = araddr_q;
    assign arsize_o = arsize_q;

    // Beat goes to whichever client owns rid
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dc_ret_valid_q <= 1'b0;
            ic_ret_valid_q <= 1'b0;
        end else begin
            dc_ret_valid_q <= r_hs && (rid_i == DC_ID);
            ic_ret_valid_q <= r_hs && (rid_i == IC_ID) && (rid_i != DC_ID);
        end
    end

    // Single beat per read, so rlast and rresp carry nothing to act on
    always_ff @(posedge clk) begin
        if (r_hs) begin
            ret_data_q <= rdata_i;
        end
    end

    assign dc_ret_valid_o = dc_ret_valid_q;
    assign ic_ret_valid_o = ic_ret_valid_q;
    assign dc_ret_data_o  = ret_data_q;
    assign ic_ret_data_o  = ret_data_q;

endmodule

// ==== verilog/axi_wr_master.sv ====
`timescale 1ns/100ps

module axi_wr_master #(
    parameter axi_pkg::axi_id_t DC_ID = 4'd1
) (
    input  logic                clk,
    input  logic                rst_n_i,

    // Data cache write client
    input  logic                dc_wr_req_i,
    input  mem_pkg::xfer_size_t dc_wr_size_i,
    input  mem_pkg::addr_t      dc_wr_addr_i,
    input  mem_pkg::strb_t      dc_wr_strb_i,
    input  mem_pkg::line_t      dc_wr_data_i,
    output logic                dc_wr_rdy_o,
    output logic                dc_wr_done_o,

    // AW channel
    output axi_pkg::axi_id_t    awid_o,
    output mem_pkg::addr_t      awaddr_o,
    output mem_pkg::xfer_size_t awsize_o,
    output logic                awvalid_o,
    input  logic                awready_i,

    // W channel
    output axi_pkg::axi_id_t    wid_o,
    output mem_pkg::line_t      wdata_o,
    output mem_pkg::strb_t      wstrb_o,
    output logic                wlast_o,
    output logic                wvalid_o,
    input  logic                wready_i,

    // B channel
    input  axi_pkg::axi_id_t    bid_i,
    input  axi_pkg::axi_resp_t  bresp_i,
    input  logic                bvalid_i,
    output logic                bready_o
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SEND,    // AW and W in flight
        WR_RESP
    } wr_state_e;

    wr_state_e  state_q;
    wr_state_e  state_d;
    logic       aw_done_q;
    logic       w_done_q;
    logic       done_q;
    logic       accept;
    logic       aw_hs;
    logic       w_hs;
    logic       b_hs;
    logic       send_ok;

    addr_t      awaddr_q;
    xfer_size_t awsize_q;
    strb_t      wstrb_q;
    line_t      wdata_q;

    assign dc_wr_rdy_o = (state_q == WR_IDLE);
    assign accept      = dc_wr_req_i && dc_wr_rdy_o;

    // Each channel drops its valid on its own handshake
    assign awvalid_o = (state_q == WR_SEND) && !aw_done_q;
    assign wvalid_o  = (state_q == WR_SEND) && !w_done_q;
    assign aw_hs     = awvalid_o && awready_i;
    assign w_hs      = wvalid_o && wready_i;
    assign send_ok   = (aw_done_q || aw_hs) && (w_done_q || w_hs);

    assign bready_o = (state_q == WR_RESP);
    assign b_hs     = bvalid_i && bready_o;  // bid and bresp not checked

    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: if (accept) state_d = WR_SEND;
            WR_SEND: if (send_ok) state_d = WR_RESP;
            WR_RESP: if (b_hs) state_d = WR_IDLE;
            default: state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= WR_IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= b_hs;
            if (accept) begin
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
            end else begin
                aw_done_q <= aw_done_q || aw_hs;
                w_done_q  <= w_done_q || w_hs;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            awaddr_q <= dc_wr_addr_i;
            awsize_q <= dc_wr_size_i;
            wstrb_q  <= dc_wr_strb_i;
            wdata_q  <= dc_wr_data_i;
        end
    end

    assign awid_o   = DC_ID;
    assign awaddr_o = awaddr_q;
    assign awsize_o = awsize_q;
    assign wid_o    = DC_ID;
    assign wdata_o  = wdata_q;
    assign wstrb_o  = wstrb_q;
    assign wlast_o  = 1'b1;     // Always the only beat

    assign dc_wr_done_o = done_q;

endmodule

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    typedef logic [31:0]  addr_t;   // Physical byte address
    typedef logic [127:0] line_t;   // Cache line, also one AXI beat
    typedef logic [15:0]  strb_t;   // One bit per line byte

    // Same encoding as AXI size, bytes = 2**size
    typedef logic [2:0] xfer_size_t;

    localparam xfer_size_t SIZE_BYTE = 3'd0;
    localparam xfer_size_t SIZE_HALF = 3'd1;
    localparam xfer_size_t SIZE_WORD = 3'd2;
    localparam xfer_size_t SIZE_LINE = 3'd4;  // Full 16-byte line

endpackage
